//--- Makefile
TOP = equihash_verify_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
	  echo "Simulation reported a failure, see sim.log"; \
	  exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- bench/equihash_verify_tb.sv
// Testbench for the index verifier with a directed table, LCG random solutions and a rule model
`default_nettype none
`timescale 1ns/1ps

module equihash_verify_tb;

  localparam int CLK_PERIOD     = 20;
  localparam int TAB_ROWS       = 14;
  localparam int RAND_SOLS      = 200;
  // Bound on the cycles of one 25 byte solution with stalls, idle gaps and bitmap clearing
  localparam int MAX_SOL_CYCLES = 400;
  localparam int WATCHDOG_NS    = (TAB_ROWS + RAND_SOLS) * MAX_SOL_CYCLES * CLK_PERIOD;
  localparam int SOL_W          = equihash_pkg::SOL_LIST_LEN * equihash_pkg::SOL_BITS;

  // Strictly increasing indices, so every rule holds
  localparam logic [SOL_W-1:0] GOOD =
    192'h010_020_030_040_050_060_070_080_090_0a0_0b0_0c0_0d0_0e0_0f0_100;
  localparam logic [SOL_W-1:0] ALT =
    192'h001_0ff_100_1ff_200_2ff_300_3ff_400_4ff_500_5ff_600_6ff_700_fff;
  // Last index repeats the first one and also breaks the last level 0 pair
  localparam logic [SOL_W-1:0] TAIL =
    192'h010_020_030_040_050_060_070_080_090_0a0_0b0_0c0_0d0_0e0_0f0_010;

  logic                               i_clk;
  logic                               i_rst;
  logic [7:0]                         i_data;
  logic                               i_valid;
  logic                               i_last;
  logic                               o_ready;
  logic [equihash_pkg::MASK_BITS-1:0] o_mask;
  logic                               o_mask_valid;

  logic [SOL_W-1:0]                   tab_sol  [TAB_ROWS];
  int                                 tab_adj  [TAB_ROWS];
  logic [equihash_pkg::MASK_BITS-1:0] tab_mask [TAB_ROWS];

  logic [equihash_pkg::SOL_BITS-1:0]  cur_idx [equihash_pkg::SOL_LIST_LEN];
  logic [equihash_pkg::MASK_BITS-1:0] mask_q [$];
  logic [31:0]                        lcg_state;
  int                                 sol_cnt;
  int                                 pulse_cnt;

  equihash_verify UUT (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_data       (i_data),
    .i_valid      (i_valid),
    .i_last       (i_last),
    .o_ready      (o_ready),
    .o_mask       (o_mask),
    .o_mask_valid (o_mask_valid)
  );

  initial i_clk = 1'b0;

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // Results are taken at the falling edge, half a cycle after the DUT updates them
  always @(negedge i_clk) begin
    if (!i_rst && o_mask_valid) begin
      mask_q.push_back(o_mask);
      pulse_cnt = pulse_cnt + 1;
    end
  end

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16]) % n;
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Every complete pair of sibling blocks must start in strictly increasing order
  function automatic logic order_model(input int n);
    logic bad;
    bad = 1'b0;
    for (int size = 1; size < equihash_pkg::SOL_LIST_LEN; size = size * 2) begin
      for (int start = 0; start + 2 * size <= n; start += 2 * size) begin
        if (cur_idx[start] >= cur_idx[start + size]) begin
          bad = 1'b1;
        end
      end
    end
    return bad;
  endfunction

  function automatic logic dup_model(input int n);
    logic found;
    found = 1'b0;
    for (int a = 0; a < n; a++) begin
      for (int b = a + 1; b < n; b++) begin
        if (cur_idx[a] == cur_idx[b]) begin
          found = 1'b1;
        end
      end
    end
    return found;
  endfunction

  function automatic logic [SOL_W-1:0] pack_indices();
    logic [SOL_W-1:0] sol;
    for (int k = 0; k < equihash_pkg::SOL_LIST_LEN; k++) begin
      sol[SOL_W-1-equihash_pkg::SOL_BITS*k -: equihash_pkg::SOL_BITS] = cur_idx[k];
    end
    return sol;
  endfunction

  task automatic set_row(input int r, input int adj,
                         input logic [equihash_pkg::MASK_BITS-1:0] mask,
                         input logic [SOL_W-1:0] sol);
    tab_sol[r]  = sol;
    tab_adj[r]  = adj;
    tab_mask[r] = mask;
  endtask

  // Mask bits are length, order, duplicate from left to right
  task automatic load_table();
    set_row(0, 0, 3'b000, GOOD);
    set_row(1, 0, 3'b010,
            192'h020_010_030_040_050_060_070_080_090_0a0_0b0_0c0_0d0_0e0_0f0_100);
    set_row(2, 0, 3'b010,
            192'h030_040_010_020_050_060_070_080_090_0a0_0b0_0c0_0d0_0e0_0f0_100);
    set_row(3, 0, 3'b010,
            192'h050_060_070_080_010_020_030_040_090_0a0_0b0_0c0_0d0_0e0_0f0_100);
    set_row(4, 0, 3'b010,
            192'h090_0a0_0b0_0c0_0d0_0e0_0f0_100_010_020_030_040_050_060_070_080);
    // Positions 1 and 2 are never compared, so only the repeat is flagged
    set_row(5, 0, 3'b001,
            192'h010_020_020_030_050_060_070_080_090_0a0_0b0_0c0_0d0_0e0_0f0_100);
    set_row(6, 0, 3'b000, GOOD);
    set_row(7, -1, 3'b100, GOOD);
    set_row(8, 0, 3'b000, GOOD);
    set_row(9, 1, 3'b100, GOOD);
    set_row(10, 0, 3'b000, ALT);
    // One byte short loses the last index, and with it the repeat and the bad pair
    set_row(11, -1, 3'b100, TAIL);
    set_row(12, 0, 3'b011, TAIL);
    set_row(13, 0, 3'b000, GOOD);
  endtask

  // Random idle cycles come first, then the byte is held until the DUT takes it
  task automatic send_byte(input logic [7:0] data, input logic last);
    logic took;
    while (rand_below(4) == 0) begin
      i_valid = 1'b0;
      @(posedge i_clk);
      #1;
    end
    i_data  = data;
    i_last  = last;
    i_valid = 1'b1;
    do begin
      took = o_ready;
      @(posedge i_clk);
      #1;
    end while (!took);
    i_valid = 1'b0;
    i_last  = 1'b0;
  endtask

  task automatic run_solution(input logic [SOL_W-1:0] sol, input int adj,
                              input logic [equihash_pkg::MASK_BITS-1:0] exp_mask);
    int         nbytes;
    logic [7:0] data;
    check_value("results pending before a solution", mask_q.size(), 0);
    nbytes = equihash_pkg::SOL_BYTES + adj;
    for (int b = 0; b < nbytes; b++) begin
      if (b < equihash_pkg::SOL_BYTES) begin
        data = sol[SOL_W-1-8*b -: 8];
      end else begin
        data = 8'(rand_below(256));
      end
      send_byte(data, b == nbytes - 1);
    end
    // Input must stay blocked until the result is out
    while (mask_q.size() == 0) begin
      check_value("o_ready while a result is due", o_ready, 0);
      @(posedge i_clk);
      #1;
    end
    check_value($sformatf("mask of solution %0d", sol_cnt), mask_q.pop_front(), exp_mask);
    sol_cnt = sol_cnt + 1;
  endtask

  // Increasing indices, then at most one swap or one copied index, and a random length
  task automatic make_random(output int adj);
    int v;
    int j;
    int k;
    logic [equihash_pkg::SOL_BITS-1:0] t;
    v = 0;
    for (int i = 0; i < equihash_pkg::SOL_LIST_LEN; i++) begin
      v = v + 1 + rand_below(200);
      cur_idx[i] = equihash_pkg::SOL_BITS'(v);
    end
    j = rand_below(equihash_pkg::SOL_LIST_LEN);
    k = rand_below(equihash_pkg::SOL_LIST_LEN);
    case (rand_below(4))
      1: begin
        t          = cur_idx[j];
        cur_idx[j] = cur_idx[k];
        cur_idx[k] = t;
      end
      2: cur_idx[j] = cur_idx[k];
      default: ;
    endcase
    case (rand_below(4))
      2: adj = -1;
      3: adj = 1;
      default: adj = 0;
    endcase
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT did not finish all solutions within the time limit");
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int adj;
    int n;
    logic [equihash_pkg::MASK_BITS-1:0] exp_mask;
    lcg_state = 32'hf196_92d1;
    i_rst     = 1'b1;
    i_data    = 8'h00;
    i_valid   = 1'b0;
    i_last    = 1'b0;
    sol_cnt   = 0;
    pulse_cnt = 0;
    load_table();

    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    check_value("o_ready at reset release", o_ready, 0);
    @(posedge i_clk);
    #1;
    check_value("o_ready one cycle after reset", o_ready, 1);

    for (int r = 0; r < TAB_ROWS; r++) begin
      run_solution(tab_sol[r], tab_adj[r], tab_mask[r]);
    end

    for (int s = 0; s < RAND_SOLS; s++) begin
      make_random(adj);
      // Only whole indices reach the checkers and an extra byte adds none
      n = (equihash_pkg::SOL_BYTES + adj) * 8 / equihash_pkg::SOL_BITS;
      if (n > equihash_pkg::SOL_LIST_LEN) begin
        n = equihash_pkg::SOL_LIST_LEN;
      end
      exp_mask = '0;
      exp_mask[equihash_pkg::MASK_DUPLICATE]  = dup_model(n);
      exp_mask[equihash_pkg::MASK_BAD_ORDER]  = order_model(n);
      exp_mask[equihash_pkg::MASK_BAD_LENGTH] = (adj != 0);
      run_solution(pack_indices(), adj, exp_mask);
    end

    // Give a stray pulse time to show up before the count is taken
    repeat (50) @(posedge i_clk);
    #1;
    if (pulse_cnt == sol_cnt) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      check_value("result pulses", pulse_cnt, sol_cnt);
    end
  end

endmodule

`default_nettype wire

//--- src.f
src/equihash_pkg.sv
src/sol_unpack.sv
src/index_order_check.sv
src/index_dup_check.sv
src/equihash_verify.sv
bench/equihash_verify_tb.sv

//--- src/equihash_pkg.sv
// Solution geometry and result mask bit positions for the index list verifier
`default_nettype none

package equihash_pkg;

  // Width of one packed index in the solution stream
  localparam int SOL_BITS = 12;

  // Number of indices carried by one solution
  localparam int SOL_LIST_LEN = 16;

  // Depth of the binary tree built over the index list
  localparam int SOL_LEVELS = $clog2(SOL_LIST_LEN);

  // The indices are packed back to back with no padding
  localparam int SOL_BYTES = SOL_LIST_LEN * SOL_BITS / 8;

  // Width of the result mask with one flag per failed rule
  localparam int MASK_BITS = 3;

  // Some index value occurs more than once
  localparam int MASK_DUPLICATE = 0;

  // A left block does not start below its right neighbour at some tree level
  localparam int MASK_BAD_ORDER = 1;

  // The stream was not SOL_BYTES long, or it stopped inside an index
  localparam int MASK_BAD_LENGTH = 2;

endpackage

`default_nettype wire

//--- src/equihash_verify.sv
// Top level of the index verifier with the unpacker, both rule checkers and the mask collector
`default_nettype none
`timescale 1ns/1ps

module equihash_verify (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic [7:0]                         i_data,
  input  logic                               i_valid,
  input  logic                               i_last,
  output logic                               o_ready,
  output logic [equihash_pkg::MASK_BITS-1:0] o_mask,
  output logic                               o_mask_valid
);

  logic [equihash_pkg::SOL_BITS-1:0] idx;
  logic                              idx_valid;
  logic                              idx_last;
  logic                              order_ready;
  logic                              dup_ready;
  logic                              order_done;
  logic                              order_bad;
  logic                              dup_done;
  logic                              dup_found;
  logic                              len_done;
  logic                              len_bad;

  // Verdicts seen so far for the solution in flight
  logic len_in_q;
  logic ord_in_q;
  logic dup_in_q;
  logic len_bad_q;
  logic ord_bad_q;
  logic dup_bad_q;
  logic all_in;

  sol_unpack u_unpack (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_data        (i_data),
    .i_valid       (i_valid),
    .i_last        (i_last),
    .i_order_ready (order_ready),
    .i_dup_ready   (dup_ready),
    .i_mask_valid  (o_mask_valid),
    .o_ready       (o_ready),
    .o_idx         (idx),
    .o_idx_valid   (idx_valid),
    .o_idx_last    (idx_last),
    .o_len_done    (len_done),
    .o_len_bad     (len_bad)
  );

  index_order_check u_order (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_idx       (idx),
    .i_idx_valid (idx_valid),
    .i_idx_last  (idx_last),
    .o_ready     (order_ready),
    .o_done      (order_done),
    .o_bad       (order_bad)
  );

  index_dup_check u_dup (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_idx       (idx),
    .i_idx_valid (idx_valid),
    .i_idx_last  (idx_last),
    .o_ready     (dup_ready),
    .o_done      (dup_done),
    .o_found     (dup_found)
  );

  // Counts a verdict arriving this cycle, so the mask follows the last one by a single cycle
  assign all_in = (len_in_q | len_done) & (ord_in_q | order_done) & (dup_in_q | dup_done);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      len_in_q     <= 1'b0;
      ord_in_q     <= 1'b0;
      dup_in_q     <= 1'b0;
      o_mask       <= '0;
      o_mask_valid <= 1'b0;
    end else begin
      o_mask_valid <= 1'b0;
      if (all_in) begin
        o_mask_valid <= 1'b1;
        o_mask[equihash_pkg::MASK_DUPLICATE]  <= dup_done ? dup_found : dup_bad_q;
        o_mask[equihash_pkg::MASK_BAD_ORDER]  <= order_done ? order_bad : ord_bad_q;
        o_mask[equihash_pkg::MASK_BAD_LENGTH] <= len_done ? len_bad : len_bad_q;
        len_in_q <= 1'b0;
        ord_in_q <= 1'b0;
        dup_in_q <= 1'b0;
      end else begin
        len_in_q <= len_in_q | len_done;
        ord_in_q <= ord_in_q | order_done;
        dup_in_q <= dup_in_q | dup_done;
      end
    end
  end

  // Each verdict flag is captured with its done pulse
  always_ff @(posedge i_clk) begin
    if (len_done) begin
      len_bad_q <= len_bad;
    end
    if (order_done) begin
      ord_bad_q <= order_bad;
    end
    if (dup_done) begin
      dup_bad_q <= dup_found;
    end
  end

endmodule

`default_nettype wire

//--- src/index_dup_check.sv
// Duplicate index detector built on a seen-bitmap that is cleared after each solution
`default_nettype none
`timescale 1ns/1ps

module index_dup_check (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic [equihash_pkg::SOL_BITS-1:0] i_idx,
  input  logic                              i_idx_valid,
  input  logic                              i_idx_last,
  output logic                              o_ready,
  output logic                              o_done,
  output logic                              o_found
);

  // One flag per possible index value
  logic [2**equihash_pkg::SOL_BITS-1:0]            seen_q;
  // Indices of the current solution, so only their flags need clearing
  logic [equihash_pkg::SOL_BITS-1:0]               rec_q [equihash_pkg::SOL_LIST_LEN];
  logic [$clog2(equihash_pkg::SOL_LIST_LEN+1)-1:0] rec_cnt_q;
  logic [$clog2(equihash_pkg::SOL_LIST_LEN)-1:0]   clr_ptr_q;
  logic                                            clearing_q;
  logic                                            found_q;
  logic                                            hit;

  // The next solution is held off while old flags are still set
  assign o_ready = ~clearing_q;

  assign hit = i_idx_valid & seen_q[i_idx];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_q     <= '0;
      rec_cnt_q  <= '0;
      clr_ptr_q  <= '0;
      clearing_q <= 1'b0;
      found_q    <= 1'b0;
      o_done     <= 1'b0;
      o_found    <= 1'b0;
    end else begin
      o_done <= i_idx_last;

      if (i_idx_valid) begin
        seen_q[i_idx] <= 1'b1;
        found_q       <= found_q | hit;
        if (rec_cnt_q < equihash_pkg::SOL_LIST_LEN) begin
          rec_cnt_q <= rec_cnt_q + 1'b1;
        end
      end

      if (i_idx_last) begin
        o_found    <= found_q | hit;
        found_q    <= 1'b0;
        clr_ptr_q  <= '0;
        clearing_q <= (rec_cnt_q != '0) | i_idx_valid;
      end

      // One recorded flag is cleared per cycle and a repeated index just gets cleared twice
      if (clearing_q) begin
        seen_q[rec_q[clr_ptr_q]] <= 1'b0;
        clr_ptr_q                <= clr_ptr_q + 1'b1;
        if ({1'b0, clr_ptr_q} + 1'b1 == rec_cnt_q) begin
          clearing_q <= 1'b0;
          rec_cnt_q  <= '0;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_idx_valid && rec_cnt_q < equihash_pkg::SOL_LIST_LEN) begin
      rec_q[rec_cnt_q[$clog2(equihash_pkg::SOL_LIST_LEN)-1:0]] <= i_idx;
    end
  end

endmodule

`default_nettype wire

//--- src/index_order_check.sv
// Tree ordering check over the index stream of one solution
`default_nettype none
`timescale 1ns/1ps

module index_order_check (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic [equihash_pkg::SOL_BITS-1:0] i_idx,
  input  logic                              i_idx_valid,
  input  logic                              i_idx_last,
  output logic                              o_ready,
  output logic                              o_done,
  output logic                              o_bad
);

  // Position of the incoming index within the solution
  logic [equihash_pkg::SOL_LEVELS-1:0] pos_q;
  // First index of the most recent left block at each level
  logic [equihash_pkg::SOL_BITS-1:0]   first_q [equihash_pkg::SOL_LEVELS];
  // Compare result of the open pair at each level, kept until the pair is complete
  logic [equihash_pkg::SOL_LEVELS-1:0] cmp_bad_q;
  logic [equihash_pkg::SOL_LEVELS-1:0] cmp_bad_nx;
  logic                                bad_q;
  logic                                bad_now;

  // Nothing here ever stalls
  assign o_ready = 1'b1;

  // At level l a pair spans 2^(l+1) indices. The right block starts halfway through the pair
  // and the pair is complete on its last index; for l = 0 both are the same index
  always_comb begin
    cmp_bad_nx = cmp_bad_q;
    bad_now    = 1'b0;
    for (int l = 0; l < equihash_pkg::SOL_LEVELS; l++) begin
      if ((pos_q & ((2 << l) - 1)) == (1 << l)) begin
        cmp_bad_nx[l] = (first_q[l] >= i_idx);
      end
      if ((pos_q & ((2 << l) - 1)) == ((2 << l) - 1)) begin
        bad_now = bad_now | cmp_bad_nx[l];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pos_q     <= '0;
      cmp_bad_q <= '0;
      bad_q     <= 1'b0;
      o_done    <= 1'b0;
      o_bad     <= 1'b0;
    end else begin
      o_done <= i_idx_last;
      if (i_idx_valid) begin
        pos_q     <= pos_q + 1'b1;
        cmp_bad_q <= cmp_bad_nx;
        bad_q     <= bad_q | bad_now;
      end
      if (i_idx_last) begin
        // A short solution simply never completes its upper pairs
        o_bad <= bad_q | (i_idx_valid & bad_now);
        pos_q <= '0;
        bad_q <= 1'b0;
      end
    end
  end

  // Left block starts are where the low l+1 position bits are all zero
  always_ff @(posedge i_clk) begin
    if (i_idx_valid) begin
      for (int l = 0; l < equihash_pkg::SOL_LEVELS; l++) begin
        if ((pos_q & ((2 << l) - 1)) == 0) begin
          first_q[l] <= i_idx;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/sol_unpack.sv
// Byte stream to index stream unpacker with a stream length check
`default_nettype none
`timescale 1ns/1ps

module sol_unpack (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic [7:0]                        i_data,
  input  logic                              i_valid,
  input  logic                              i_last,
  input  logic                              i_order_ready,
  input  logic                              i_dup_ready,
  input  logic                              i_mask_valid,
  output logic                              o_ready,
  output logic [equihash_pkg::SOL_BITS-1:0] o_idx,
  output logic                              o_idx_valid,
  output logic                              o_idx_last,
  output logic                              o_len_done,
  output logic                              o_len_bad
);

  // Partial index, shifted in most significant bit first
  logic [equihash_pkg::SOL_BITS-1:0]                part_q;
  logic [equihash_pkg::SOL_BITS-1:0]                part_nx;
  logic [$clog2(equihash_pkg::SOL_BITS+1)-1:0]      bit_cnt_q;
  logic [$clog2(equihash_pkg::SOL_BITS+1)-1:0]      bit_cnt_nx;
  logic [equihash_pkg::SOL_BITS-1:0]                idx_new;
  logic                                             idx_done;
  // Saturates, so an over-long stream can never wrap back onto SOL_BYTES
  logic [$clog2(equihash_pkg::SOL_BYTES+1)-1:0]     byte_cnt_q;
  logic [$clog2(equihash_pkg::SOL_LIST_LEN+1)-1:0]  sent_cnt_q;
  logic                                             started_q;
  logic                                             wait_q;
  logic                                             idx_full_q;
  logic                                             idx_last_q;
  logic                                             idx_end_q;
  logic                                             sinks_ready;
  logic                                             accept;
  logic                                             emit;

  // Walk the byte one bit at a time; with SOL_BITS >= 8 at most one index completes
  always_comb begin
    part_nx    = part_q;
    bit_cnt_nx = bit_cnt_q;
    idx_new    = part_q;
    idx_done   = 1'b0;
    for (int b = 7; b >= 0; b--) begin
      part_nx    = {part_nx[equihash_pkg::SOL_BITS-2:0], i_data[b]};
      bit_cnt_nx = bit_cnt_nx + 1'b1;
      if (bit_cnt_nx == equihash_pkg::SOL_BITS) begin
        idx_new    = part_nx;
        idx_done   = 1'b1;
        bit_cnt_nx = '0;
      end
    end
  end

  assign sinks_ready = i_order_ready & i_dup_ready;
  assign o_ready     = started_q & ~wait_q & ~idx_full_q & ~idx_end_q;
  assign accept      = i_valid & o_ready;

  // Anything past SOL_LIST_LEN indices belongs to an over-long stream and is dropped
  assign emit = idx_done & (sent_cnt_q < equihash_pkg::SOL_LIST_LEN);

  // Both checkers must see a beat on the same cycle, so it is only shown when both can take it.
  // An end beat without an index closes a short or long stream whose last byte held no index
  assign o_idx_valid = idx_full_q & sinks_ready;
  assign o_idx_last  = ((idx_full_q & idx_last_q) | idx_end_q) & sinks_ready;

  // Length verdict on the cycle the final byte is taken
  assign o_len_done = accept & i_last;
  assign o_len_bad  = (byte_cnt_q + 1 != equihash_pkg::SOL_BYTES) || (bit_cnt_nx != '0);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      started_q  <= 1'b0;
      wait_q     <= 1'b0;
      idx_full_q <= 1'b0;
      idx_last_q <= 1'b0;
      idx_end_q  <= 1'b0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      sent_cnt_q <= '0;
    end else begin
      started_q <= 1'b1;
      if (i_mask_valid) begin
        wait_q <= 1'b0;
      end
      if ((idx_full_q | idx_end_q) & sinks_ready) begin
        idx_full_q <= 1'b0;
        idx_end_q  <= 1'b0;
      end
      if (accept) begin
        bit_cnt_q <= bit_cnt_nx;
        if (byte_cnt_q != '1) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
        end
        if (emit) begin
          idx_full_q <= 1'b1;
          idx_last_q <= i_last;
          sent_cnt_q <= sent_cnt_q + 1'b1;
        end
        if (i_last) begin
          // Input stays blocked until the result mask for this solution is out
          wait_q     <= 1'b1;
          bit_cnt_q  <= '0;
          byte_cnt_q <= '0;
          sent_cnt_q <= '0;
          if (!emit) begin
            if (sent_cnt_q == '0) begin
              // With no whole index at all a zero index still closes the solution
              idx_full_q <= 1'b1;
              idx_last_q <= 1'b1;
            end else begin
              idx_end_q <= 1'b1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      part_q <= part_nx;
    end
    if (accept && emit) begin
      o_idx <= idx_new;
    end else if (accept && i_last && sent_cnt_q == '0) begin
      o_idx <= '0;
    end
  end

endmodule

`default_nettype wire
